// ==== source/mvau_macros.svh ====
// Array sizes and data widths of the MVAU
// Included by the packages and by every module that sizes a loop or an array
`ifndef MVAU_MACROS_SVH
`define MVAU_MACROS_SVH

// Lanes per input word
`define MVAU_SIMD 4
// Processing elements, one weight row each per pass
`define MVAU_PE 4
// Input words per activation vector
`define MVAU_SF 4
// Passes per vector, one row group each
`define MVAU_NF 3
// Unsigned activation width
`define MVAU_TA 4
// Signed weight width
`define MVAU_TW 4
// Signed accumulator width
`define MVAU_TO 16
// Weight memory entries per PE
`define MVAU_WMEM_DEPTH (`MVAU_SF * `MVAU_NF)

`endif

// ==== source/mvau_types_pkg.sv ====
// Data path types of the MVAU, shared by the buffer, the PEs and the collector
`include "mvau_macros.svh"

package mvau_types_pkg;

   // One unsigned activation
   typedef logic [`MVAU_TA-1:0] act_t;
   // One signed weight
   typedef logic signed [`MVAU_TW-1:0] wgt_t;
   // One signed accumulator
   typedef logic signed [`MVAU_TO-1:0] sum_t;

   // SIMD activations, lane 0 in the low bits
   typedef logic [`MVAU_SIMD*`MVAU_TA-1:0] act_word_t;
   // SIMD weights, one weight memory entry
   typedef logic [`MVAU_SIMD*`MVAU_TW-1:0] wgt_word_t;

   // All PE sums of one pass, PE 0 in the low bits
   typedef logic [`MVAU_PE*`MVAU_TO-1:0] out_word_t;

endpackage

// ==== source/mvau_ctrl_pkg.sv ====
// Control types of the MVAU, used for counters, weight addressing and the pass phase
`include "mvau_macros.svh"

package mvau_ctrl_pkg;

   // Word index within a vector
   typedef logic [$clog2(`MVAU_SF)-1:0] sf_idx_t;
   // Pass index within a vector
   typedef logic [$clog2(`MVAU_NF)-1:0] nf_idx_t;
   // Weight memory address, pass times SF plus word
   typedef logic [$clog2(`MVAU_WMEM_DEPTH)-1:0] wmem_addr_t;
   // PE select for weight writes
   typedef logic [$clog2(`MVAU_PE)-1:0] pe_idx_t;

   // Fill consumes the input stream, reuse replays the buffer
   typedef enum logic {PHASE_FILL, PHASE_REUSE} mvau_phase_e;

endpackage

// ==== source/mvau_stream_if.sv ====
// Broadcast lane stream from the input buffer to all PEs
// The buffer drives the src side, every PE listens on the pe side
`timescale 1ns/1ns

interface mvau_stream_if import mvau_types_pkg::*, mvau_ctrl_pkg::*; ();

   // One word per cycle, no back-pressure
   logic       valid;
   // SIMD activations of the word
   act_word_t  act;
   // Weight memory entry that goes with the word
   wmem_addr_t addr;
   // Word index 0, restarts the accumulators
   logic       first;
   // Word index SF-1, closes the pass
   logic       last;

   modport src (
      output valid,
      output act,
      output addr,
      output first,
      output last
   );

   modport pe (
      input valid,
      input act,
      input addr,
      input first,
      input last
   );

endinterface

// ==== source/mvau_control_block.sv ====
// Sequences the fill and reuse passes of one vector
// Word and pass counters plus the linear weight memory address
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_control_block import mvau_ctrl_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        in_v,
   output logic        step,
   output sf_idx_t     sf_cnt,
   output logic        first,
   output logic        last,
   output wmem_addr_t  wmem_addr,
   output mvau_phase_e phase
);

   // Pass counter, 0 during the fill
   nf_idx_t nf_cnt;
   logic    nf_last;
   logic    wmem_last;

   // Fill waits for input words, reuse runs every cycle
   assign step = in_v | (phase == PHASE_REUSE);

   // Word position flags, decoded from the counter
   assign first = (sf_cnt == '0);
   assign last = (sf_cnt == sf_idx_t'(`MVAU_SF - 1));

   assign nf_last = (nf_cnt == nf_idx_t'(`MVAU_NF - 1));
   assign wmem_last = (wmem_addr == wmem_addr_t'(`MVAU_WMEM_DEPTH - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_cnt    <= '0;
         nf_cnt    <= '0;
         wmem_addr <= '0;
         phase     <= PHASE_FILL;
      end else if (step) begin
         // Word counter wraps at the end of every pass
         sf_cnt <= last ? '0 : sf_cnt + 1'b1;

         // Address runs linearly across all passes of a vector
         wmem_addr <= wmem_last ? '0 : wmem_addr + 1'b1;

         if (last) begin
            if (nf_last) begin
               // Final pass done, wait for the next vector
               nf_cnt <= '0;
               phase  <= PHASE_FILL;
            end else begin
               // Remaining passes replay the buffer
               nf_cnt <= nf_cnt + 1'b1;
               phase  <= PHASE_REUSE;
            end
         end
      end
   end

endmodule

// ==== source/mvau_input_buffer.sv ====
// Captures the fill pass of a vector and replays it for the reuse passes
// Drives the registered lane stream that all PEs share
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_input_buffer import mvau_types_pkg::*, mvau_ctrl_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_v,
   input  act_word_t  in_act,
   output logic       busy,
   mvau_stream_if.src strm
);

   logic        step;
   sf_idx_t     sf_cnt;
   logic        first;
   logic        last;
   wmem_addr_t  wmem_addr;
   mvau_phase_e phase;

   // One vector, SF words deep
   act_word_t   buf_mem [`MVAU_SF];
   act_word_t   word_sel;

   mvau_control_block u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_v      (in_v),
      .step      (step),
      .sf_cnt    (sf_cnt),
      .first     (first),
      .last      (last),
      .wmem_addr (wmem_addr),
      .phase     (phase)
   );

   // Source must hold off while the buffer replays
   assign busy = (phase == PHASE_REUSE);

   // Fill forwards the live word, reuse reads it back
   assign word_sel = busy ? buf_mem[sf_cnt] : in_act;

   always_ff @(posedge clk) begin
      if (in_v && (phase == PHASE_FILL)) begin
         buf_mem[sf_cnt] <= in_act;
      end
   end

   // Stream valid lags the step by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         strm.valid <= 1'b0;
      end else begin
         strm.valid <= step;
      end
   end

   always_ff @(posedge clk) begin
      strm.act   <= word_sel;
      strm.addr  <= wmem_addr;
      strm.first <= first;
      strm.last  <= last;
   end

endmodule

// ==== source/mvau_pe.sv ====
// One processing element, owns the weight rows of its PE index
// Weight read, SIMD dot product, then accumulation over the SF words of a pass
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_pe import mvau_types_pkg::*, mvau_ctrl_pkg::*; #(
   parameter int PE_IDX = 0
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       wgt_we,
   input  pe_idx_t    wgt_pe,
   input  wmem_addr_t wgt_addr,
   input  wgt_word_t  wgt_data,
   mvau_stream_if.pe  strm,
   output sum_t       sum,
   output logic       done
);

   // SIMD weights per entry, one entry per word and pass
   wgt_word_t wmem [`MVAU_WMEM_DEPTH];

   // Stage 1 registers
   wgt_word_t wgt_q;
   act_word_t act_q;
   logic      v_q;
   logic      first_q;
   logic      last_q;

   // Stage 2 product sum
   sum_t      dot;

   // Loaded by the testbench while the unit is idle
   always_ff @(posedge clk) begin
      if (wgt_we && (wgt_pe == pe_idx_t'(PE_IDX))) begin
         wmem[wgt_addr] <= wgt_data;
      end
   end

   always_ff @(posedge clk) begin
      wgt_q   <= wmem[strm.addr];
      act_q   <= strm.act;
      first_q <= strm.first;
      last_q  <= strm.last;
   end

   // Signed weight times unsigned activation, summed over the lanes
   always_comb begin
      wgt_t w;
      act_t a;
      dot = '0;
      for (int l = 0; l < `MVAU_SIMD; l++) begin
         w   = wgt_q[l*`MVAU_TW +: `MVAU_TW];
         a   = act_q[l*`MVAU_TA +: `MVAU_TA];
         dot = dot + sum_t'(w) * sum_t'(a);
      end
   end

   // First word restarts the row, sum holds the result after last
   always_ff @(posedge clk) begin
      if (v_q) begin
         sum <= first_q ? dot : sum + dot;
      end
   end

   // done lands two cycles after the stream word with last
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q  <= 1'b0;
         done <= 1'b0;
      end else begin
         v_q  <= strm.valid;
         done <= v_q & last_q;
      end
   end

endmodule

// ==== source/mvau_output_collector.sv ====
// Packs the PE sums of one pass into a single output word
// out_v pulses one cycle after the PEs finish a pass
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_output_collector import mvau_types_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      pe_done,
   input  sum_t      pe_sum [`MVAU_PE],
   output logic      out_v,
   output out_word_t out_data
);

   // Single cycle strobe, never held
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_v <= 1'b0;
      end else begin
         out_v <= pe_done;
      end
   end

   // PE 0 in the low bits, value kept until the next pass
   always_ff @(posedge clk) begin
      if (pe_done) begin
         for (int p = 0; p < `MVAU_PE; p++) begin
            out_data[p*`MVAU_TO +: `MVAU_TO] <= pe_sum[p];
         end
      end
   end

endmodule

// ==== source/mvau_top.sv ====
// MVAU top level with plain ports for input, weight load and results
// One input buffer feeds MVAU_PE processing elements through a shared stream
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_top import mvau_types_pkg::*, mvau_ctrl_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       in_v,
   input  act_word_t  in_act,
   input  logic       wgt_we,
   input  pe_idx_t    wgt_pe,
   input  wmem_addr_t wgt_addr,
   input  wgt_word_t  wgt_data,
   output logic       busy,
   output logic       out_v,
   output out_word_t  out_data
);

   mvau_stream_if strm ();

   sum_t              pe_sum [`MVAU_PE];
   logic [`MVAU_PE-1:0] pe_done_all;

   mvau_input_buffer u_buf (
      .clk    (clk),
      .rst_n  (rst_n),
      .in_v   (in_v),
      .in_act (in_act),
      .busy   (busy),
      .strm   (strm.src)
   );

   for (genvar g = 0; g < `MVAU_PE; g++) begin : g_pe
      mvau_pe #(.PE_IDX(g)) u_pe (
         .clk      (clk),
         .rst_n    (rst_n),
         .wgt_we   (wgt_we),
         .wgt_pe   (wgt_pe),
         .wgt_addr (wgt_addr),
         .wgt_data (wgt_data),
         .strm     (strm.pe),
         .sum      (pe_sum[g]),
         .done     (pe_done_all[g])
      );
   end

   // All PEs run in lockstep, PE 0 marks the end of a pass
   mvau_output_collector u_coll (
      .clk      (clk),
      .rst_n    (rst_n),
      .pe_done  (pe_done_all[0]),
      .pe_sum   (pe_sum),
      .out_v    (out_v),
      .out_data (out_data)
   );

endmodule

// ==== dv/mvau_checker.sv ====
// Protocol and latency assertions on the MVAU top level
// Attached to every mvau_top instance by the bind at the end of this file
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_checker import mvau_ctrl_pkg::*; (
   input logic clk,
   input logic rst_n,
   input logic in_v,
   input logic busy,
   input logic out_v
);

   // Failed assertions so far, polled by the testbench
   int unsigned err_cnt = 0;

   // Position of the next fill word within its vector
   sf_idx_t fill_cnt;
   logic    last_fill;

   assign last_fill = in_v && (fill_cnt == sf_idx_t'(`MVAU_SF - 1));

   // in_v only ever arrives in the fill phase
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_cnt <= '0;
      end else if (in_v) begin
         fill_cnt <= last_fill ? '0 : fill_cnt + 1'b1;
      end
   end

   // Collector is held quiet by the reset
   out_v_in_reset: assert property (@(posedge clk) !rst_n && $past(!rst_n) |-> !out_v)
      else begin
         $error("out_v high while rst_n is low");
         err_cnt++;
      end

   // One cycle strobe per pass
   out_v_single: assert property (@(posedge clk) disable iff (!rst_n) out_v |=> !out_v)
      else begin
         $error("out_v high for two cycles in a row");
         err_cnt++;
      end

   // Source holds off during reuse
   no_input_when_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !in_v)
      else begin
         $error("in_v high while busy");
         err_cnt++;
      end

   // Fill pass result after buffer, two PE stages and the collector
   fill_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $past(last_fill, 4) |-> out_v)
      else begin
         $error("out_v missing 4 cycles after the last fill word");
         err_cnt++;
      end

endmodule

bind mvau_top mvau_checker u_checker (
   .clk   (clk),
   .rst_n (rst_n),
   .in_v  (in_v),
   .busy  (busy),
   .out_v (out_v)
);

// ==== dv/mvau_tb.sv ====
// Testbench for the MVAU top level
// Random weights and vectors, a reference model of the sums and an in-order result monitor
`timescale 1ns/1ns
`include "mvau_macros.svh"

module mvau_tb import mvau_types_pkg::*, mvau_ctrl_pkg::*; ();

   // Cycles any single wait may take
   localparam int TIMEOUT = 200;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       in_v;
   act_word_t  in_act;
   logic       wgt_we;
   pe_idx_t    wgt_pe;
   wmem_addr_t wgt_addr;
   wgt_word_t  wgt_data;
   logic       busy;
   logic       out_v;
   out_word_t  out_data;

   integer     seed = 32'hb2365d8c;
   // Weight rows per PE and the vector sent last
   wgt_word_t  wgt_model [`MVAU_PE][`MVAU_WMEM_DEPTH];
   act_word_t  vec_model [`MVAU_SF];
   // Results still owed by the DUT, oldest first
   out_word_t  exp_q [$];

   mvau_top DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_v     (in_v),
      .in_act   (in_act),
      .wgt_we   (wgt_we),
      .wgt_pe   (wgt_pe),
      .wgt_addr (wgt_addr),
      .wgt_data (wgt_data),
      .busy     (busy),
      .out_v    (out_v),
      .out_data (out_data)
   );

   always #10 clk = ~clk;

   task automatic stop_on_failure();
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   // Inputs change 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_until_idle();
      int n;
      n = 0;
      while (busy) begin
         if (n == TIMEOUT) begin
            $display("Timeout at %0t ns waiting for busy to drop", $time);
            stop_on_failure();
         end
         n++;
         next_cycle();
      end
   endtask

   // All owed results seen, pipeline empty
   task automatic wait_results_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == TIMEOUT) begin
            $display("Timeout at %0t ns waiting for out_v", $time);
            stop_on_failure();
         end
         n++;
         next_cycle();
      end
   endtask

   // New random rows for every PE, one entry per cycle
   task automatic load_weights();
      for (int p = 0; p < `MVAU_PE; p++) begin
         for (int a = 0; a < `MVAU_WMEM_DEPTH; a++) begin
            wgt_model[p][a] = wgt_word_t'($random(seed));
            wgt_we   = 1'b1;
            wgt_pe   = pe_idx_t'(p);
            wgt_addr = wmem_addr_t'(a);
            wgt_data = wgt_model[p][a];
            next_cycle();
         end
      end
      wgt_we = 1'b0;
   endtask

   // Row n*PE+p times the vector, one word per pass with PE 0 lowest
   task automatic push_expected();
      out_word_t exp;
      int        acc;
      int        w;
      int        a;
      int        addr;
      for (int n = 0; n < `MVAU_NF; n++) begin
         exp = '0;
         for (int p = 0; p < `MVAU_PE; p++) begin
            acc = 0;
            for (int s = 0; s < `MVAU_SF; s++) begin
               addr = n * `MVAU_SF + s;
               for (int l = 0; l < `MVAU_SIMD; l++) begin
                  // Weights signed, activations unsigned
                  w   = $signed(wgt_model[p][addr][l*`MVAU_TW +: `MVAU_TW]);
                  a   = int'(vec_model[s][l*`MVAU_TA +: `MVAU_TA]);
                  acc = acc + w * a;
               end
            end
            exp[p*`MVAU_TO +: `MVAU_TO] = acc[`MVAU_TO-1:0];
         end
         exp_q.push_back(exp);
      end
   endtask

   // One random vector, optionally with idle cycles between fill words
   task automatic send_vector(input bit with_gaps);
      int gap;
      wait_until_idle();
      for (int s = 0; s < `MVAU_SF; s++) begin
         vec_model[s] = act_word_t'($random(seed));
      end
      push_expected();
      for (int s = 0; s < `MVAU_SF; s++) begin
         if (with_gaps) begin
            gap = int'($unsigned($random(seed)) % 4);
            repeat (gap) next_cycle();
         end
         in_v   = 1'b1;
         in_act = vec_model[s];
         next_cycle();
         in_v   = 1'b0;
      end
   endtask

   // Outputs settle on the rising edge, sampled on the falling one
   always @(negedge clk) begin
      if (rst_n && out_v) begin
         assert (exp_q.size() != 0) else begin
            $display("out_v at %0t ns with no result expected", $time);
            stop_on_failure();
         end
         assert (out_data == exp_q[0]) else begin
            $display("Mismatch at %0t ns: out_data expected %h, actual %h",
                     $time, exp_q[0], out_data);
            stop_on_failure();
         end
         void'(exp_q.pop_front());
      end
      assert (DUT.u_checker.err_cnt == 0) else begin
         $display("Protocol checker assertion failed before %0t ns", $time);
         stop_on_failure();
      end
   end

   initial begin
      rst_n    = 1'b0;
      in_v     = 1'b0;
      in_act   = '0;
      wgt_we   = 1'b0;
      wgt_pe   = '0;
      wgt_addr = '0;
      wgt_data = '0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Quiet after reset without input
      repeat (8) begin
         next_cycle();
         assert (!out_v && !busy) else begin
            $display("out_v or busy high without input at %0t ns", $time);
            stop_on_failure();
         end
      end

      load_weights();

      // Single vector, contiguous fill
      send_vector(1'b0);
      wait_results_drained();

      // Fill with random gaps
      send_vector(1'b1);
      wait_results_drained();

      // Back to back, each as soon as busy drops
      repeat (4) send_vector(1'b0);
      send_vector(1'b1);
      wait_results_drained();

      // New weights while idle
      load_weights();
      send_vector(1'b0);
      wait_results_drained();

      repeat (10) next_cycle();
      if (DUT.u_checker.err_cnt == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Protocol checker assertion failed at the end of the run");
         stop_on_failure();
      end
   end

endmodule

// ==== all.f ====
+incdir+source
source/mvau_types_pkg.sv
source/mvau_ctrl_pkg.sv
source/mvau_stream_if.sv
source/mvau_control_block.sv
source/mvau_input_buffer.sv
source/mvau_pe.sv
source/mvau_output_collector.sv
source/mvau_top.sv
dv/mvau_checker.sv
dv/mvau_tb.sv

// ==== Makefile ====
# Verilator build and run of the MVAU testbench
VERILATOR ?= verilator
TOP       ?= mvau_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
